// File: rtl/shallow_pkg.sv
// shared widths and request/response structs for the wide port and its lanes, imported by all RTL
`default_nettype none

package shallow_pkg;

  // data width of one lane, equal to one bank word
  localparam int unsigned LANE_DW  = 32;
  // data width of the wide initiator port
  localparam int unsigned WIDE_DW  = 128;
  // number of 32-bit lanes carried by one wide word
  localparam int unsigned NB_LANES = WIDE_DW / LANE_DW;
  // byte address width on the wide port
  localparam int unsigned ADDR_W   = 32;

  // request as issued by the wide initiator
  typedef struct packed {
    // high for a read, low for a write
    logic                 wen;
    // one enable per byte of the wide word
    logic [WIDE_DW/8-1:0] be;
    // byte address, 4-byte aligned
    logic [ADDR_W-1:0]    addr;
    logic [WIDE_DW-1:0]   data;
  } wide_req_t;

  // response to the wide initiator, lane 0 in the low bits
  typedef struct packed {
    logic [WIDE_DW-1:0] rdata;
  } wide_rsp_t;

  // one lane of a wide request, already addressed to a bank row
  typedef struct packed {
    logic                 req;
    logic                 wen;
    logic [LANE_DW/8-1:0] be;
    // word index inside the bank
    logic [ADDR_W-1:0]    row;
    logic [LANE_DW-1:0]   data;
  } lane_req_t;

  // bank answer, gnt is same cycle, rvalid and rdata follow one cycle later
  typedef struct packed {
    logic               gnt;
    logic               rvalid;
    logic [LANE_DW-1:0] rdata;
  } lane_rsp_t;

endpackage

`default_nettype wire

// File: rtl/req_fifo.sv
// request FIFO for any payload type, placed in front of the router; depth 0 makes it a pass-through
`default_nettype none

module req_fifo #(
  parameter type         payload_t  = logic [31:0],
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     clear_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  output logic          full_o,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          valid_o
);

  if (FIFO_DEPTH == 0) begin : g_bypass
    // the head is the incoming request itself
    assign data_o  = data_i;
    // a clear drops the request on the floor
    assign valid_o = push_i & ~clear_i;
    // the request is taken only when the router pops it
    assign full_o  = ~pop_i;
  end else begin : g_buffer
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;

    // pointers and fill count, wrapping at the depth
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push_i) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop_i) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
      end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
      if (push_i) begin
        mem_q[wr_ptr_q] <= data_i;
      end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign valid_o = (cnt_q != '0);
    // refuse pushes while flushing so no request slips past a clear
    assign full_o  = (cnt_q == CNT_W'(FIFO_DEPTH)) | clear_i;

    // the initiator side must respect full
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o))
      else $error("push into a full request FIFO");
  end

  // the router only pops a valid head
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_o)
    else $error("pop from an empty request FIFO");

endmodule

`default_nettype wire

// File: rtl/lane_split.sv
// splits the wide head request into 32-bit lane requests with their bank row and bank offset
`default_nettype none

module lane_split #(
  parameter int unsigned NB_BANKS = 8
) (
  input  wire shallow_pkg::wide_req_t                     head_i,
  input  wire logic                                       head_valid_i,
  input  wire logic                                       commit_i,
  output shallow_pkg::lane_req_t [shallow_pkg::NB_LANES-1:0] lanes_o,
  output logic [$clog2(NB_BANKS)-1:0]                     offset_o
);

  import shallow_pkg::*;

  // bank index bits sit right above the byte offset
  localparam int unsigned OFF_W = $clog2(NB_BANKS);

  logic [ADDR_W-1:0] base_row;
  logic              lane_req;

  // first bank hit by lane 0
  assign offset_o = head_i.addr[OFF_W+1:2];

  // row shared by all lanes that do not wrap past the last bank
  assign base_row = ADDR_W'(head_i.addr[ADDR_W-1:OFF_W+2]);

  // lanes only request when the control has committed the whole word,
  // so a busy bank never sees a partial write
  assign lane_req = head_valid_i & commit_i;

  for (genvar k = 0; k < NB_LANES; k++) begin : g_lane
    logic wrap;

    // lane lands on a bank below the offset, i.e. in the next row
    assign wrap = (int'(offset_o) + k) >= int'(NB_BANKS);

    assign lanes_o[k].req  = lane_req;
    assign lanes_o[k].wen  = head_i.wen;
    // byte enables and data of this lane's 32-bit slice
    assign lanes_o[k].be   = head_i.be[k*(LANE_DW/8) +: LANE_DW/8];
    assign lanes_o[k].data = head_i.data[k*LANE_DW +: LANE_DW];
    assign lanes_o[k].row  = base_row + ADDR_W'(wrap);
  end

  // a wide word must fit in the bank set
  initial begin
    assert (NB_BANKS >= NB_LANES)
      else $error("fewer banks than lanes");
    assert (2 ** OFF_W == NB_BANKS)
      else $error("bank count is not a power of two");
  end

endmodule

`default_nettype wire

// File: rtl/bank_rotate.sv
// rotating crossbar between lanes and banks, lane k to bank offset+k, and back in lane order
`default_nettype none

module bank_rotate #(
  parameter int unsigned NB_BANKS = 8
) (
  input  wire logic [$clog2(NB_BANKS)-1:0]                  offset_i,
  input  wire shallow_pkg::lane_req_t [shallow_pkg::NB_LANES-1:0] lanes_i,
  output shallow_pkg::lane_rsp_t [shallow_pkg::NB_LANES-1:0]      lane_rsp_o,
  output logic [shallow_pkg::NB_LANES-1:0]                  lane_busy_o,
  output shallow_pkg::lane_req_t [NB_BANKS-1:0]             bank_req_o,
  input  wire shallow_pkg::lane_rsp_t [NB_BANKS-1:0]        bank_rsp_i,
  input  wire logic [NB_BANKS-1:0]                          bank_busy_i
);

  import shallow_pkg::*;

  localparam int unsigned OFF_W  = $clog2(NB_BANKS);
  localparam int unsigned LANE_W = (NB_LANES > 1) ? $clog2(NB_LANES) : 1;

  logic [NB_BANKS-1:0] bank_req_vec;

  // request direction, bank b is served by lane b-offset if that lane exists
  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    logic [OFF_W-1:0] lane_sel;

    // modulo arithmetic comes for free with a power-of-two bank count
    assign lane_sel = OFF_W'(b) - offset_i;

    // untargeted banks get an idle request
    assign bank_req_o[b] = (int'(lane_sel) < int'(NB_LANES)) ?
                           lanes_i[lane_sel[LANE_W-1:0]] : '0;

    assign bank_req_vec[b] = bank_req_o[b].req;
  end

  // response direction, lane k reads back from bank offset+k
  for (genvar k = 0; k < NB_LANES; k++) begin : g_lane
    logic [OFF_W-1:0] bank_sel;

    assign bank_sel = offset_i + OFF_W'(k);

    assign lane_rsp_o[k]  = bank_rsp_i[bank_sel];
    // busy level of the bank this lane will hit, used before committing
    assign lane_busy_o[k] = bank_busy_i[bank_sel];
  end

  // a wide request never touches more banks than it has lanes
  always_comb begin : req_count_check
    assert ($countones(bank_req_vec) <= NB_LANES)
      else $error("more banks requested than lanes");
  end

endmodule

`default_nettype wire

// File: rtl/tcdm_bank.sv
// single-port 32-bit memory bank with byte enables, grant in the request cycle, response one later
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BANK_WORDS = 64
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire shallow_pkg::lane_req_t req_i,
  // contention from other masters, a level
  input  wire logic                   busy_i,
  output shallow_pkg::lane_rsp_t      rsp_o
);

  import shallow_pkg::*;

  localparam int unsigned IDX_W = $clog2(BANK_WORDS);

  logic [LANE_DW-1:0] mem_q [BANK_WORDS];
  logic [IDX_W-1:0]   idx;
  logic               gnt;
  logic               rvalid_q;
  logic [LANE_DW-1:0] rdata_q;

  assign idx = req_i.row[IDX_W-1:0];

  // granted whenever asked and nobody else holds the bank
  assign gnt = req_i.req & ~busy_i;

  // one response pulse per grant, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  // array access, write honours byte enables
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= mem_q[idx];
      if (!req_i.wen) begin
        for (int i = 0; i < LANE_DW / 8; i++) begin
          if (req_i.be[i]) begin
            mem_q[idx][8*i +: 8] <= req_i.data[8*i +: 8];
          end
        end
      end
    end
  end

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  // the router must never address a row beyond this bank
  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt |-> req_i.row < BANK_WORDS)
    else $error("bank row out of range");

endmodule

`default_nettype wire

// File: rtl/router_ctrl.sv
// router control, commits a wide request when its banks are free and filters the response valid
`default_nettype none

module router_ctrl (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          clear_i,
  input  wire logic                          head_valid_i,
  // busy and grant of the targeted banks, in lane order
  input  wire logic [shallow_pkg::NB_LANES-1:0] lane_busy_i,
  input  wire logic [shallow_pkg::NB_LANES-1:0] lane_gnt_i,
  output logic                               commit_o,
  output logic                               pop_o,
  input  wire logic                          lane0_rvalid_i,
  output logic                               rvalid_o
);

  logic pop_q;

  // all or nothing, no lane goes out while any target is busy
  // nor while the queue is being flushed
  assign commit_o = head_valid_i & ~clear_i & ~(|lane_busy_i);

  // wide grant once every lane is granted
  assign pop_o = &lane_gnt_i;

  // remember the accepted request so only its response passes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pop_q <= 1'b0;
    end else if (clear_i) begin
      pop_q <= 1'b0;
    end else begin
      pop_q <= pop_o;
    end
  end

  // lane 0 speaks for the whole word, all lanes answer together
  assign rvalid_o = lane0_rvalid_i & pop_q;

  // banks only grant lanes that the control committed
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_o |-> commit_o)
    else $error("lanes granted without commit");

  // every accepted request is answered in the next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_o |=> rvalid_o)
    else $error("accepted request got no response");

  // and nothing else produces a response
  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> $past(pop_o))
    else $error("response without an accepted request");

endmodule

`default_nettype wire

// File: rtl/wide_mem_sub.sv
// top of the wide-port memory subsystem, FIFO and shallow router in front of eight banks
`default_nettype none

module wide_mem_sub #(
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned BANK_WORDS = 64,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   clear_i,
  input  wire logic                   req_i,
  input  wire shallow_pkg::wide_req_t wreq_i,
  output logic                        gnt_o,
  input  wire logic [NB_BANKS-1:0]    bank_busy_i,
  output logic                        rvalid_o,
  output shallow_pkg::wide_rsp_t      rsp_o
);

  import shallow_pkg::*;

  localparam int unsigned OFF_W = $clog2(NB_BANKS);

  wide_req_t                head;
  logic                     head_valid;
  logic                     fifo_push;
  logic                     fifo_full;
  logic                     commit;
  logic                     pop;
  logic [OFF_W-1:0]         offset;
  logic [OFF_W-1:0]         offset_q;
  lane_req_t [NB_LANES-1:0] lane_req;
  lane_rsp_t [NB_LANES-1:0] lane_rsp;
  logic [NB_LANES-1:0]      lane_busy;
  logic [NB_LANES-1:0]      lane_gnt;
  logic [NB_LANES-1:0]      lane_rvalid;
  lane_req_t [NB_BANKS-1:0] bank_req;
  lane_rsp_t [NB_BANKS-1:0] bank_rsp;

  // with a real queue push only when there is room,
  // in bypass the request is offered and full tells whether it was taken
  if (FIFO_DEPTH == 0) begin : g_push_bypass
    assign fifo_push = req_i;
  end else begin : g_push_queue
    assign fifo_push = req_i & ~fifo_full;
  end

  // accepted when the queue, or the router in bypass, takes the request
  assign gnt_o = req_i & ~fifo_full;

  req_fifo #(
    .payload_t  (wide_req_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .push_i  (fifo_push),
    .data_i  (wreq_i),
    .full_o  (fifo_full),
    .pop_i   (pop),
    .data_o  (head),
    .valid_o (head_valid)
  );

  lane_split #(.NB_BANKS(NB_BANKS)) u_split (
    .head_i       (head),
    .head_valid_i (head_valid),
    .commit_i     (commit),
    .lanes_o      (lane_req),
    .offset_o     (offset)
  );

  bank_rotate #(.NB_BANKS(NB_BANKS)) u_rotate (
    .offset_i    (offset),
    .lanes_i     (lane_req),
    .lane_rsp_o  (lane_rsp),
    .lane_busy_o (lane_busy),
    .bank_req_o  (bank_req),
    .bank_rsp_i  (bank_rsp),
    .bank_busy_i (bank_busy_i)
  );

  router_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .head_valid_i   (head_valid),
    .lane_busy_i    (lane_busy),
    .lane_gnt_i     (lane_gnt),
    .commit_o       (commit),
    .pop_o          (pop),
    .lane0_rvalid_i (lane_rvalid[0]),
    .rvalid_o       (rvalid_o)
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    tcdm_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (bank_req[b]),
      .busy_i (bank_busy_i[b]),
      .rsp_o  (bank_rsp[b])
    );
  end

  // offset of the accepted word, its banks answer one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (pop) begin
      offset_q <= offset;
    end
  end

  // lane k fills bits [32k+31:32k] of the wide response
  for (genvar k = 0; k < NB_LANES; k++) begin : g_rsp
    logic [OFF_W-1:0] rsp_bank;

    // the head may already have moved on by the response cycle
    assign rsp_bank = offset_q + OFF_W'(k);

    assign lane_gnt[k]                       = lane_rsp[k].gnt;
    assign lane_rvalid[k]                    = bank_rsp[rsp_bank].rvalid;
    assign rsp_o.rdata[k*LANE_DW +: LANE_DW] = bank_rsp[rsp_bank].rdata;
  end

  // a filtered response always has every lane of the word behind it
  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> &lane_rvalid)
    else $error("wide response with a missing lane");

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// testbench clock and reset source, instantiated by the wide memory testbench
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD     = 40,
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset held low for a fixed number of rising edges
  initial begin
    rst_no <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_wide_mem.sv
// table-driven testbench for the wide memory subsystem, checks it against a flat word model
`default_nettype none

module tb_wide_mem;

  import shallow_pkg::*;

  localparam int NB_BANKS   = 8;
  localparam int BANK_WORDS = 64;
  localparam int MEM_WORDS  = NB_BANKS * BANK_WORDS;
  localparam int TIMEOUT    = 200;
  // cycles a busy mask is held before it is dropped
  localparam int HOLD       = 6;
  localparam int NSTEPS     = 19;

  typedef struct packed {
    logic                 rd;
    // take the data from the LFSR instead of the table
    logic                 rnd;
    logic [ADDR_W-1:0]    addr;
    logic [WIDE_DW/8-1:0] be;
    logic [WIDE_DW-1:0]   data;
    logic [NB_BANKS-1:0]  busy;
  } step_t;

  logic                clk;
  logic                rst_n;
  logic                clear_i;
  logic                req_i;
  wide_req_t           wreq_i;
  logic                gnt_o;
  logic [NB_BANKS-1:0] bank_busy_i;
  logic                rvalid_o;
  wide_rsp_t           rsp_o;

  logic [LANE_DW-1:0]  model_q [MEM_WORDS];
  wide_rsp_t           exp_q [$];
  bit                  chk_q [$];
  logic [31:0]         lfsr_q = 32'h9bd4_65c3;
  int                  err_cnt = 0;
  int                  chk_cnt = 0;

  // word offsets 0..7 and wrap cases, partial enables, then busy masks on and off target
  step_t steps [NSTEPS] = '{
    '{1'b0, 1'b1, 32'h40, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h40, 16'hffff, 128'h0, 8'h00},
    '{1'b0, 1'b1, 32'h14, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h14, 16'hffff, 128'h0, 8'h00},
    '{1'b0, 1'b1, 32'h98, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h98, 16'hffff, 128'h0, 8'h00},
    '{1'b0, 1'b1, 32'hdc, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'hdc, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h08, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h2c, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h64, 16'hffff, 128'h0, 8'h00},
    '{1'b0, 1'b0, 32'h24, 16'h0f35, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 8'h00},
    '{1'b1, 1'b0, 32'h24, 16'hffff, 128'h0, 8'h00},
    '{1'b0, 1'b0, 32'h7c, 16'h8001, 128'hdead_beef_0000_0000_0000_0000_cafe_f00d, 8'h00},
    '{1'b1, 1'b0, 32'h7c, 16'hffff, 128'h0, 8'h00},
    '{1'b1, 1'b0, 32'h40, 16'hffff, 128'h0, 8'h04},
    '{1'b0, 1'b1, 32'h1c, 16'hffff, 128'h0, 8'h01},
    '{1'b1, 1'b0, 32'h1c, 16'hffff, 128'h0, 8'h78},
    '{1'b1, 1'b0, 32'h30, 16'hffff, 128'h0, 8'h0f}
  };

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(16)) u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wide_mem_sub #(
    .NB_BANKS   (NB_BANKS),
    .BANK_WORDS (BANK_WORDS),
    .FIFO_DEPTH (2)
  ) dut_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .clear_i     (clear_i),
    .req_i       (req_i),
    .wreq_i      (wreq_i),
    .gnt_o       (gnt_o),
    .bank_busy_i (bank_busy_i),
    .rvalid_o    (rvalid_o),
    .rsp_o       (rsp_o)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per data bit
  task automatic draw_data(output logic [WIDE_DW-1:0] v);
    for (int i = 0; i < WIDE_DW; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i] = lfsr_q[0];
    end
  endtask

  // banks hit by a wide word, bank index from addr[4:2] with eight banks
  function automatic logic [NB_BANKS-1:0] target_banks(logic [ADDR_W-1:0] addr);
    logic [NB_BANKS-1:0] m;
    m = '0;
    for (int k = 0; k < NB_LANES; k++) begin
      m[(int'(addr[4:2]) + k) % NB_BANKS] = 1'b1;
    end
    return m;
  endfunction

  // flat model, lane k is word addr[31:2] + k
  function automatic void model_write(wide_req_t r);
    int w;
    for (int k = 0; k < NB_LANES; k++) begin
      w = (int'(r.addr[ADDR_W-1:2]) + k) % MEM_WORDS;
      for (int b = 0; b < LANE_DW / 8; b++) begin
        if (r.be[4*k+b]) begin
          model_q[w][8*b +: 8] = r.data[LANE_DW*k + 8*b +: 8];
        end
      end
    end
  endfunction

  function automatic wide_rsp_t model_read(logic [ADDR_W-1:0] addr);
    wide_rsp_t rsp;
    int        w;
    for (int k = 0; k < NB_LANES; k++) begin
      w = (int'(addr[ADDR_W-1:2]) + k) % MEM_WORDS;
      rsp.rdata[LANE_DW*k +: LANE_DW] = model_q[w];
    end
    return rsp;
  endfunction

  task automatic cmp_rsp(string what, wide_rsp_t got, wide_rsp_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got.rdata,
               exp.rdata);
      err_cnt++;
    end
  endtask

  task automatic cmp_bit(string what, logic got, logic exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(string name, int e0);
    $display("%s: %s", name, (err_cnt == e0) ? "ok" : "failed");
  endtask

  // accepted request updates the model, reads queue their expected data
  task automatic accept_req(wide_req_t r);
    if (r.wen) begin
      exp_q.push_back(model_read(r.addr));
      chk_q.push_back(1'b1);
    end else begin
      model_write(r);
      exp_q.push_back('0);
      chk_q.push_back(1'b0);
    end
  endtask

  task automatic issue_req(wide_req_t r, logic [NB_BANKS-1:0] busy, bit track);
    bit granted;
    granted = 1'b0;
    @(posedge clk);
    req_i       <= 1'b1;
    wreq_i      <= r;
    bank_busy_i <= busy;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      if (gnt_o) begin
        granted = 1'b1;
        break;
      end
    end
    if (!granted) begin
      $display("Error at time %0t: request to %h was never granted", $time, r.addr);
      err_cnt++;
    end else if (track) begin
      accept_req(r);
    end
    @(posedge clk);
    req_i <= 1'b0;
  endtask

  task automatic check_next(wide_rsp_t got);
    wide_rsp_t e;
    bit        c;
    if (exp_q.size() == 0) begin
      $display("Error at time %0t: response arrived with no request pending", $time);
      err_cnt++;
    end else begin
      e = exp_q.pop_front();
      c = chk_q.pop_front();
      if (c) begin
        cmp_rsp("read data", got, e);
      end
    end
  endtask

  // collects n responses, busy dropped at cycle hold, lat is the cycle of the last one
  task automatic await_rsp(int n, int hold, output int lat);
    int got;
    got = 0;
    lat = 0;
    for (int i = 1; i <= TIMEOUT; i++) begin
      @(posedge clk);
      if (i == hold) begin
        bank_busy_i <= '0;
      end
      @(negedge clk);
      if (rvalid_o) begin
        got++;
        check_next(rsp_o);
        if (got == n) begin
          lat = i;
          break;
        end
      end
    end
    if (got != n) begin
      $display("Error at time %0t: only %0d of %0d responses arrived", $time, got, n);
      err_cnt++;
    end
  endtask

  task automatic expect_quiet(int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      cmp_bit("rvalid_o with nothing pending", rvalid_o, 1'b0);
    end
  endtask

  task automatic run_step(step_t s);
    wide_req_t r;
    int        lat;
    logic      hit;
    r.wen  = s.rd;
    r.be   = s.be;
    r.addr = s.addr;
    r.data = s.data;
    if (s.rnd) begin
      draw_data(r.data);
    end
    hit = |(s.busy & target_banks(s.addr));
    issue_req(r, s.busy, 1'b1);
    await_rsp(1, HOLD, lat);
    // a stalled request only answers after its banks are released
    cmp_bit("stalled by busy banks", lat > HOLD, hit);
    @(posedge clk);
    bank_busy_i <= '0;
  endtask

  initial begin : main
    int        e0;
    int        lat;
    wide_req_t r;
    step_t     s;
    req_i       <= 1'b0;
    clear_i     <= 1'b0;
    wreq_i      <= '0;
    bank_busy_i <= '0;

    // outputs quiet in reset and on the first cycle out of it
    e0 = err_cnt;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      cmp_bit("gnt_o around reset", gnt_o, 1'b0);
      cmp_bit("rvalid_o around reset", rvalid_o, 1'b0);
      if (rst_n) begin
        break;
      end
    end
    if (!rst_n) begin
      $display("Error at time %0t: reset was never released", $time);
      err_cnt++;
    end
    report_test("reset", e0);

    // known contents for words 0..63
    e0 = err_cnt;
    for (int w = 0; w < 16; w++) begin
      s = '{1'b0, 1'b1, 32'(w * 16), 16'hffff, 128'h0, 8'h00};
      run_step(s);
    end
    report_test("fill", e0);

    for (int i = 0; i < NSTEPS; i++) begin
      e0 = err_cnt;
      run_step(steps[i]);
      report_test($sformatf("step %0d %s addr %h busy %h", i, steps[i].rd ? "read" : "write",
                            steps[i].addr, steps[i].busy), e0);
    end

    // write then read queued behind busy banks, answered in order
    e0 = err_cnt;
    r.wen  = 1'b0;
    r.be   = '1;
    r.addr = 32'h50;
    draw_data(r.data);
    issue_req(r, '1, 1'b1);
    r.wen = 1'b1;
    issue_req(r, '1, 1'b1);
    await_rsp(2, 1, lat);
    expect_quiet(4);
    report_test("in-order responses", e0);

    // two writes queued, a third refused, then flushed
    e0 = err_cnt;
    r.wen  = 1'b0;
    r.addr = 32'h84;
    draw_data(r.data);
    issue_req(r, '1, 1'b0);
    r.addr = 32'ha8;
    draw_data(r.data);
    issue_req(r, '1, 1'b0);
    r.addr = 32'hc0;
    @(posedge clk);
    req_i  <= 1'b1;
    wreq_i <= r;
    @(negedge clk);
    cmp_bit("gnt_o with a full FIFO", gnt_o, 1'b0);
    @(posedge clk);
    req_i   <= 1'b0;
    clear_i <= 1'b1;
    @(posedge clk);
    clear_i     <= 1'b0;
    bank_busy_i <= '0;
    expect_quiet(8);
    s = '{1'b1, 1'b0, 32'h84, 16'hffff, 128'h0, 8'h00};
    run_step(s);
    s.addr = 32'ha8;
    run_step(s);
    report_test("clear", e0);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/shallow_pkg.sv
rtl/req_fifo.sv
rtl/lane_split.sv
rtl/bank_rotate.sv
rtl/tcdm_bank.sv
rtl/router_ctrl.sv
rtl/wide_mem_sub.sv
tests/tb_clk_gen.sv
tests/tb_wide_mem.sv

// File: run_sim.sh
#!/bin/sh
# builds the wide memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wide_mem -f all.f -o tb_wide_mem
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/tb_wide_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' sim.log; then
  exit 1
fi

exit 0
